/* build.f */
src/cache_pkg.sv
src/cache_array.sv
src/data_array.sv
src/bus_adapter.sv
src/cache_datapath.sv
src/cache_control.sv
src/cache.sv
verification/pmem_model.sv
verification/cache_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module cache_tb -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -q "TEST OK" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed, see sim.log."
    exit 1
fi

/* verification/cache_tb.sv */
// Cache testbench
`timescale 1ns/10ps

module cache_tb;

    localparam int s_index  = 3;
    localparam int num_sets = 2**s_index;
    localparam int s_tag    = 32 - cache_pkg::s_offset - s_index;

    typedef enum logic {op_read, op_write} op_t;

    typedef struct packed {
        op_t              op;
        cache_pkg::word_t addr;
        cache_pkg::word_t wdata;
        cache_pkg::be_t   be;
        logic             exp_miss;
    } access_t;

    logic             clk;
    logic             rst_n;
    logic             mem_read;
    logic             mem_write;
    cache_pkg::word_t mem_address;
    cache_pkg::word_t mem_wdata;
    cache_pkg::be_t   mem_byte_enable;
    cache_pkg::word_t mem_rdata;
    logic             mem_resp;
    logic             pmem_read;
    logic             pmem_write;
    cache_pkg::word_t pmem_address;
    cache_pkg::line_t pmem_wdata;
    cache_pkg::line_t pmem_rdata;
    logic             pmem_resp;

    access_t          tests[$];
    string            names[$];
    logic [7:0]       gold_mem [cache_pkg::word_t];
    logic [s_tag-1:0] tag_m [num_sets][2];
    logic             valid_m [num_sets][2];
    logic             dirty_m [num_sets][2];
    logic             lru_m [num_sets];
    int               cycle_count;
    int               cycle_limit;

    cache #(.s_index(s_index)) DUT (.*);

    pmem_model #(.delay(3)) mem_model (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            cycle_count = cycle_count + 1;
            if (cycle_count >= cycle_limit)
            begin
                $display("Timeout: the tests did not finish within %0d cycles.", cycle_limit);
                $display("TEST FAILED");
                $fatal(1);
            end
        end
    end

    task automatic check(input string what, input cache_pkg::line_t expected,
                         input cache_pkg::line_t actual);
        if (expected !== actual)
        begin
            $display("FAIL %s: expected %0h, actual %0h", what, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Same fill pattern as the memory model.
    function automatic logic [7:0] gold_byte(cache_pkg::word_t a);
        cache_pkg::word_t base;
        cache_pkg::word_t w;
        base = a & 32'hffff_fffc;
        w    = {base[15:0], base[31:16]} ^ 32'h3c5a_96e1;
        if (gold_mem.exists(a))
        begin
            return gold_mem[a];
        end
        return w[8*a[1:0] +: 8];
    endfunction

    function automatic cache_pkg::word_t gold_word(cache_pkg::word_t a);
        cache_pkg::word_t w;
        for (int i = 0; i < 4; i++)
        begin
            w[8*i +: 8] = gold_byte((a & 32'hffff_fffc) + 32'(i));
        end
        return w;
    endfunction

    function automatic cache_pkg::line_t gold_line(cache_pkg::word_t a);
        cache_pkg::line_t l;
        for (int i = 0; i < 32; i++)
        begin
            l[8*i +: 8] = gold_byte((a & 32'hffff_ffe0) + 32'(i));
        end
        return l;
    endfunction

    // Two-way tag and LRU model; the LRU bit names the next victim.
    task automatic model_access(input access_t e, output logic miss, output logic wb,
                                output cache_pkg::word_t wb_addr);
        logic [s_index-1:0] set;
        logic [s_tag-1:0]   tag;
        logic               way;
        set     = e.addr[cache_pkg::s_offset +: s_index];
        tag     = e.addr[31 -: s_tag];
        miss    = 1'b1;
        wb      = 1'b0;
        way     = 1'b0;
        wb_addr = '0;
        for (int w = 0; w < 2; w++)
        begin
            if (valid_m[set][w] && tag_m[set][w] == tag)
            begin
                miss = 1'b0;
                way  = 1'(w);
            end
        end
        if (miss)
        begin
            way     = lru_m[set];
            wb      = valid_m[set][way] && dirty_m[set][way];
            wb_addr = {tag_m[set][way], set, 5'b0};
            tag_m[set][way]   = tag;
            valid_m[set][way] = 1'b1;
            dirty_m[set][way] = 1'b0;
        end
        lru_m[set] = (way == 1'b0);
        if (e.op == op_write)
        begin
            dirty_m[set][way] = 1'b1;
        end
    endtask

    task automatic add_test(input op_t op, input cache_pkg::word_t addr, input cache_pkg::be_t be,
                            input logic exp_miss, input string name);
        access_t e;
        e.op       = op;
        e.addr     = addr;
        e.wdata    = (op == op_write) ? $urandom() : '0;
        e.be       = be;
        e.exp_miss = exp_miss;
        tests.push_back(e);
        names.push_back(name);
    endtask

    task automatic run_access(input access_t e, input string name);
        logic             model_miss;
        logic             exp_wb;
        cache_pkg::word_t exp_wb_addr;
        cache_pkg::line_t exp_wb_line;
        logic             saw_read;
        logic             saw_write;
        cache_pkg::word_t rd_addr;
        cache_pkg::word_t wr_addr;
        cache_pkg::line_t wr_data;
        cache_pkg::word_t rdata;
        model_access(e, model_miss, exp_wb, exp_wb_addr);
        exp_wb_line = gold_line(exp_wb_addr); // Victim contents before this access.
        saw_read    = 1'b0;
        saw_write   = 1'b0;
        rd_addr     = '0;
        wr_addr     = '0;
        wr_data     = '0;
        @(posedge clk);
        mem_read        <= (e.op == op_read);
        mem_write       <= (e.op == op_write);
        mem_address     <= e.addr;
        mem_wdata       <= e.wdata;
        mem_byte_enable <= e.be;
        do
        begin
            @(negedge clk);
            if (pmem_read && !saw_read)
            begin
                saw_read = 1'b1;
                rd_addr  = pmem_address;
            end
            if (pmem_write && !saw_write)
            begin
                saw_write = 1'b1;
                wr_addr   = pmem_address;
                wr_data   = pmem_wdata;
            end
        end
        while (!mem_resp);
        rdata = mem_rdata;
        @(posedge clk);
        mem_read  <= 1'b0;
        mem_write <= 1'b0;

        check({name, " miss"}, 256'(e.exp_miss), 256'(saw_read));
        check({name, " lru model"}, 256'(model_miss), 256'(saw_read));
        if (saw_read)
        begin
            check({name, " fill addr"}, 256'(e.addr & 32'hffff_ffe0), 256'(rd_addr));
        end
        check({name, " writeback"}, 256'(exp_wb), 256'(saw_write));
        if (exp_wb)
        begin
            check({name, " wb addr"}, 256'(exp_wb_addr), 256'(wr_addr));
            check({name, " wb data"}, exp_wb_line, wr_data);
            check({name, " backdoor"}, exp_wb_line, mem_model.peek(exp_wb_addr));
        end
        if (e.op == op_read)
        begin
            check({name, " rdata"}, 256'(gold_word(e.addr)), 256'(rdata));
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (e.be[i])
                begin
                    gold_mem[(e.addr & 32'hffff_fffc) + 32'(i)] = e.wdata[8*i +: 8];
                end
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'hccfe_fe95));
        rst_n           = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_address     = '0;
        mem_wdata       = '0;
        mem_byte_enable = '0;
        cycle_count     = 0;
        cycle_limit     = 1000;
        for (int s = 0; s < num_sets; s++)
        begin
            lru_m[s] = 1'b0;
            for (int w = 0; w < 2; w++)
            begin
                tag_m[s][w]   = '0;
                valid_m[s][w] = 1'b0;
                dirty_m[s][w] = 1'b0;
            end
        end

        add_test(op_read,  32'h0000_0524, 4'b1111, 1'b1, "read_miss");
        add_test(op_read,  32'h0000_0528, 4'b1111, 1'b0, "read_hit");
        add_test(op_write, 32'h0000_052c, 4'b0110, 1'b0, "write_hit_partial");
        add_test(op_read,  32'h0000_052c, 4'b1111, 1'b0, "read_merged");
        add_test(op_read,  32'h0000_1040, 4'b1111, 1'b1, "evict_fill_a");
        add_test(op_write, 32'h0000_1054, 4'b1111, 1'b0, "evict_dirty_a");
        add_test(op_read,  32'h0000_2048, 4'b1111, 1'b1, "evict_fill_b");
        add_test(op_read,  32'h0000_3040, 4'b1111, 1'b1, "evict_wb_c");
        add_test(op_read,  32'h0000_1054, 4'b1111, 1'b1, "evict_reload_a");
        add_test(op_read,  32'h0000_4060, 4'b1111, 1'b1, "lru_a");
        add_test(op_read,  32'h0000_5060, 4'b1111, 1'b1, "lru_b");
        add_test(op_read,  32'h0000_4064, 4'b1111, 1'b0, "lru_a_again");
        add_test(op_read,  32'h0000_6060, 4'b1111, 1'b1, "lru_c");
        add_test(op_read,  32'h0000_4068, 4'b1111, 1'b0, "lru_a_hit");
        add_test(op_read,  32'h0000_5060, 4'b1111, 1'b1, "lru_b_miss");
        add_test(op_write, 32'h0000_7004, 4'b1001, 1'b1, "write_miss");
        add_test(op_read,  32'h0000_7004, 4'b1111, 1'b0, "write_miss_read");
        cycle_limit = tests.size() * 40;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        foreach (tests[i])
        begin
            run_access(tests[i], names[i]);
        end

        $display("TEST OK");
        $finish;
    end

endmodule : cache_tb

/* verification/pmem_model.sv */
// Behavioral line memory
`timescale 1ns/10ps

module pmem_model #(
    parameter int delay = 3
)
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pmem_read,
    input  logic             pmem_write,
    input  cache_pkg::word_t pmem_address,
    input  cache_pkg::line_t pmem_wdata,
    output cache_pkg::line_t pmem_rdata,
    output logic             pmem_resp
);

    cache_pkg::line_t mem [cache_pkg::word_t];
    int               count;

    // Lines never written read back as a pattern of their word addresses.
    function automatic cache_pkg::line_t peek(cache_pkg::word_t addr);
        cache_pkg::word_t base;
        cache_pkg::word_t a;
        cache_pkg::line_t line;
        base = addr & 32'hffff_ffe0;
        if (mem.exists(base))
        begin
            return mem[base];
        end
        for (int w = 0; w < 8; w++)
        begin
            a = base + 32'(4*w);
            line[32*w +: 32] = {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
        end
        return line;
    endfunction

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count      <= 0;
            pmem_resp  <= 1'b0;
            pmem_rdata <= '0;
        end
        else
        begin
            pmem_resp <= 1'b0;
            if ((pmem_read || pmem_write) && !pmem_resp)
            begin
                if (count == delay - 1)
                begin
                    count     <= 0;
                    pmem_resp <= 1'b1; // Answer on the delay-th edge.
                    if (pmem_write)
                    begin
                        mem[pmem_address & 32'hffff_ffe0] = pmem_wdata;
                    end
                    else
                    begin
                        pmem_rdata <= peek(pmem_address);
                    end
                end
                else
                begin
                    count <= count + 1;
                end
            end
        end
    end

endmodule : pmem_model

/* src/cache.sv */
// Two-way write-back cache
`timescale 1ns/10ps

module cache #(
    parameter int s_index = 3
)
(
    input  logic             clk,
    input  logic             rst_n,

    // CPU port.
    input  logic             mem_read,
    input  logic             mem_write,
    input  cache_pkg::word_t mem_address,
    input  cache_pkg::word_t mem_wdata,
    input  cache_pkg::be_t   mem_byte_enable,
    output cache_pkg::word_t mem_rdata,
    output logic             mem_resp,

    // Physical memory port.
    output logic             pmem_read,
    output logic             pmem_write,
    output cache_pkg::word_t pmem_address,
    output cache_pkg::line_t pmem_wdata,
    input  cache_pkg::line_t pmem_rdata,
    input  logic             pmem_resp
);

    cache_pkg::cache_ctrl_t   ctrl;
    cache_pkg::cache_status_t status;
    cache_pkg::line_t         mem_wdata256;
    cache_pkg::mask_t         mem_byte_enable256;
    cache_pkg::line_t         line_rdata;

    cache_control control (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .status     (status),
        .pmem_resp  (pmem_resp),
        .ctrl       (ctrl),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write)
    );

    cache_datapath #(.s_index(s_index)) datapath (
        .clk                (clk),
        .rst_n              (rst_n),
        .mem_address        (mem_address),
        .ctrl               (ctrl),
        .status             (status),
        .mem_wdata256       (mem_wdata256),
        .mem_byte_enable256 (mem_byte_enable256),
        .pmem_rdata         (pmem_rdata),
        .line_rdata         (line_rdata),
        .pmem_wdata         (pmem_wdata),
        .pmem_address       (pmem_address)
    );

    bus_adapter adapter (
        .address            (mem_address),
        .mem_wdata          (mem_wdata),
        .mem_byte_enable    (mem_byte_enable),
        .line_rdata         (line_rdata),
        .mem_wdata256       (mem_wdata256),
        .mem_byte_enable256 (mem_byte_enable256),
        .mem_rdata          (mem_rdata)
    );

endmodule : cache

/* src/cache_control.sv */
// Cache control FSM
`timescale 1ns/10ps

module cache_control
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     mem_read,
    input  logic                     mem_write,
    input  cache_pkg::cache_status_t status,
    input  logic                     pmem_resp,
    output cache_pkg::cache_ctrl_t   ctrl,
    output logic                     mem_resp,
    output logic                     pmem_read,
    output logic                     pmem_write
);

    typedef enum logic [1:0] {
        st_idle,
        st_compare,
        st_writeback,
        st_fill
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        ctrl       = '0;
        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;

        unique case (state)
            st_idle:
            begin
                if (mem_read || mem_write)
                begin
                    next_state = st_compare;
                end
            end
            st_compare:
            begin
                if (!(mem_read || mem_write))
                begin
                    next_state = st_idle;
                end
                else if (status.hit)
                begin
                    mem_resp       = 1'b1;
                    ctrl.set_lru   = 1'b1;
                    ctrl.load_data = mem_write; // Merge bytes into the hit way.
                    ctrl.cpu_write = mem_write;
                    ctrl.set_dirty = mem_write;
                    next_state     = st_idle;
                end
                else
                begin
                    next_state = status.dirty ? st_writeback : st_fill;
                end
            end
            st_writeback:
            begin
                pmem_write   = 1'b1;
                ctrl.wb_addr = 1'b1;
                if (pmem_resp)
                begin
                    next_state = st_fill;
                end
            end
            st_fill:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    ctrl.load_data = 1'b1;
                    ctrl.load_tag  = 1'b1;
                    ctrl.set_valid = 1'b1;
                    ctrl.clr_dirty = 1'b1;
                    next_state     = st_compare;
                end
            end
            default:
            begin
                next_state = st_idle;
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write both high.");

    // Response is a single-cycle pulse.
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp |=> !mem_resp)
        else $error("mem_resp held for more than one cycle.");

endmodule : cache_control

/* src/cache_datapath.sv */
// Two-way cache datapath
`timescale 1ns/10ps

module cache_datapath #(
    parameter int s_index = 3
)
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  cache_pkg::word_t         mem_address,
    input  cache_pkg::cache_ctrl_t   ctrl,
    output cache_pkg::cache_status_t status,
    input  cache_pkg::line_t         mem_wdata256,
    input  cache_pkg::mask_t         mem_byte_enable256,
    input  cache_pkg::line_t         pmem_rdata,
    output cache_pkg::line_t         line_rdata,
    output cache_pkg::line_t         pmem_wdata,
    output cache_pkg::word_t         pmem_address
);

    localparam int s_offset = cache_pkg::s_offset;
    localparam int s_tag    = 32 - s_offset - s_index;

    logic [s_tag-1:0]   addr_tag;
    logic [s_index-1:0] idx;
    logic [s_tag-1:0]   tag_out [2];
    logic [1:0]         valid_out;
    logic [1:0]         dirty_out;
    logic [1:0]         way_hit;
    cache_pkg::line_t   line_out [2];
    cache_pkg::line_t   line_in;
    cache_pkg::mask_t   line_mask;
    logic               lru_out;
    logic               lru_in;
    logic               way_sel;

    assign addr_tag = mem_address[31 -: s_tag];
    assign idx      = mem_address[s_offset +: s_index];

    assign way_hit[0] = valid_out[0] && (tag_out[0] == addr_tag);
    assign way_hit[1] = valid_out[1] && (tag_out[1] == addr_tag);

    assign status.hit   = |way_hit;
    assign status.dirty = dirty_out[lru_out]; // LRU bit names the victim.

    // Point the LRU bit at the way that did not hit.
    assign lru_in = way_hit[0];

    // CPU writes go to the hit way, fills to the victim.
    assign way_sel   = ctrl.cpu_write ? way_hit[1] : lru_out;
    assign line_in   = ctrl.cpu_write ? mem_wdata256 : pmem_rdata;
    assign line_mask = ctrl.cpu_write ? mem_byte_enable256 : '1;

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        logic             sel;
        cache_pkg::mask_t we;

        assign sel = (way_sel == 1'(w));
        assign we  = (ctrl.load_data && sel) ? line_mask : '0;

        cache_array #(.s_index(s_index), .width(s_tag)) tag_array (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (ctrl.load_tag && sel),
            .rindex  (idx),
            .windex  (idx),
            .datain  (addr_tag),
            .dataout (tag_out[w])
        );

        cache_array #(.s_index(s_index), .width(1)) valid_array (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (ctrl.set_valid && sel),
            .rindex  (idx),
            .windex  (idx),
            .datain  (1'b1),
            .dataout (valid_out[w])
        );

        cache_array #(.s_index(s_index), .width(1)) dirty_array (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    ((ctrl.set_dirty || ctrl.clr_dirty) && sel),
            .rindex  (idx),
            .windex  (idx),
            .datain  (ctrl.set_dirty),
            .dataout (dirty_out[w])
        );

        data_array #(.s_index(s_index)) line_array (
            .clk      (clk),
            .rst_n    (rst_n),
            .write_en (we),
            .index    (idx),
            .datain   (line_in),
            .dataout  (line_out[w])
        );
    end

    cache_array #(.s_index(s_index), .width(1)) lru_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (ctrl.set_lru),
        .rindex  (idx),
        .windex  (idx),
        .datain  (lru_in),
        .dataout (lru_out)
    );

    assign line_rdata = line_out[way_hit[1]];
    assign pmem_wdata = line_out[lru_out];

    assign pmem_address = ctrl.wb_addr ?
                          {tag_out[lru_out], idx, {s_offset{1'b0}}} :
                          {mem_address[31:s_offset], {s_offset{1'b0}}};

    // A fill only loads a tag that missed in both ways.
    assert property (@(posedge clk) disable iff (!rst_n) !(way_hit[0] && way_hit[1]))
        else $error("Both cache ways hit.");

endmodule : cache_datapath

/* src/bus_adapter.sv */
// CPU word to line adapter
`timescale 1ns/10ps

module bus_adapter
(
    input  cache_pkg::word_t address,
    input  cache_pkg::word_t mem_wdata,
    input  cache_pkg::be_t   mem_byte_enable,
    input  cache_pkg::line_t line_rdata,
    output cache_pkg::line_t mem_wdata256,
    output cache_pkg::mask_t mem_byte_enable256,
    output cache_pkg::word_t mem_rdata
);

    localparam int s_slots = cache_pkg::s_mask / 4;

    logic [cache_pkg::s_offset-3:0] slot;

    // Word slot within the line.
    assign slot = address[cache_pkg::s_offset-1:2];

    // The same word sits in every slot, so the mask alone picks the target.
    assign mem_wdata256 = {s_slots{mem_wdata}};

    always_comb
    begin
        mem_byte_enable256 = '0;
        mem_byte_enable256[4*slot +: 4] = mem_byte_enable;
    end

    assign mem_rdata = line_rdata[32*slot +: 32];

endmodule : bus_adapter

/* src/data_array.sv */
// Byte-enabled line storage
`timescale 1ns/10ps

module data_array #(
    parameter int s_index = 3
)
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::mask_t     write_en,
    input  logic [s_index-1:0]   index,
    input  cache_pkg::line_t     datain,
    output cache_pkg::line_t     dataout
);

    localparam int num_sets = 2**s_index;
    localparam int s_mask   = cache_pkg::s_mask;

    cache_pkg::line_t data [num_sets];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < num_sets; i++)
            begin
                data[i] <= '0;
            end
        end
        else
        begin
            // Only the masked bytes change.
            for (int b = 0; b < s_mask; b++)
            begin
                if (write_en[b])
                begin
                    data[index][8*b +: 8] <= datain[8*b +: 8];
                end
            end
        end
    end

    assign dataout = data[index];

endmodule : data_array

/* src/cache_array.sv */
// Per-set metadata array
`timescale 1ns/10ps

module cache_array #(
    parameter int s_index = 3,
    parameter int width   = 1
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  logic [s_index-1:0] rindex,
    input  logic [s_index-1:0] windex,
    input  logic [width-1:0]   datain,
    output logic [width-1:0]   dataout
);

    localparam int num_sets = 2**s_index;

    logic [width-1:0] data [num_sets];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < num_sets; i++)
            begin
                data[i] <= '0;
            end
        end
        else if (load)
        begin
            data[windex] <= datain;
        end
    end

    assign dataout = data[rindex]; // Combinational read.

endmodule : cache_array

/* src/cache_pkg.sv */
// Cache shared types
package cache_pkg;

    // Byte offset bits within a 32-byte line.
    localparam int s_offset = 5;

    // Bytes and bits per line.
    localparam int s_mask = 2**s_offset;
    localparam int s_line = 8*s_mask;

    // Processor address or data word.
    typedef logic [31:0] word_t;

    // One cache line.
    typedef logic [s_line-1:0] line_t;

    // Byte enables for a line and for a word.
    typedef logic [s_mask-1:0] mask_t;
    typedef logic [3:0] be_t;

    // Control strobes from the FSM to the datapath.
    typedef struct packed {
        logic load_data;  // Write the line array.
        logic cpu_write;  // Line data and mask come from the CPU.
        logic load_tag;
        logic set_valid;
        logic set_dirty;
        logic clr_dirty;
        logic set_lru;
        logic wb_addr;    // Physical address from the victim tag.
    } cache_ctrl_t;

    // Status from the datapath back to the FSM.
    typedef struct packed {
        logic hit;
        logic dirty;      // Victim line is dirty.
    } cache_status_t;

endpackage : cache_pkg
